// ==== run_sim.sh ====
#!/bin/sh
# Compile the core and its testbench with Verilator, run, and check the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_rv_core \
    -f rv_core_top.f -o sim_tb_rv_core
./obj_dir/sim_tb_rv_core > sim.log 2>&1
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1

// ==== rv_core_top.f ====
src/rv_pkg.sv
src/alu.sv
src/imm_extend.sv
src/register_file.sv
src/control_fsm.sv
src/core_datapath.sv
src/local_mem.sv
src/rv_core_top.sv
verif/tb_rv_core.sv

// ==== src/alu.sv ====
/*
 * Combinational 64-bit ALU with zero flag.
 */

`timescale 1ns/1ps

module alu
    import rv_pkg::*;
(
    input  alu_op_e i_op,
    input  xlen_t   i_a,
    input  xlen_t   i_b,
    output xlen_t   o_result,
    output logic    o_zero
);

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            // Set-less-than results are a single bit.
            ALU_SLT:  o_result = {63'b0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU: o_result = {63'b0, i_a < i_b};
            default:  o_result = '0;
        endcase
    end

    // SUB leaves zero here when the branch operands are equal.
    assign o_zero = (o_result == '0);

endmodule

// ==== src/control_fsm.sv ====
/*
 * Multicycle control FSM. Walks each instruction through its states
 * and drives one control word per state.
 */

`timescale 1ns/1ps

module control_fsm
    import rv_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_start,
    input  decode_t i_dec,
    output ctrl_t   o_ctrl,
    output logic    o_busy,
    output logic    o_halt
);

    fsm_state_e state, next_state;
    alu_op_e    r_alu_op;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // R-type operation from funct3 and funct7 bit 5.
    always_comb begin
        case (i_dec.funct3)
            3'b000:  r_alu_op = i_dec.funct7_5 ? ALU_SUB : ALU_ADD;
            3'b010:  r_alu_op = ALU_SLT;
            3'b011:  r_alu_op = ALU_SLTU;
            3'b100:  r_alu_op = ALU_XOR;
            3'b110:  r_alu_op = ALU_OR;
            3'b111:  r_alu_op = ALU_AND;
            default: r_alu_op = ALU_ADD;
        endcase
    end

    //--------------------------------------------------
    // Next state and control word.
    //--------------------------------------------------
    always_comb begin
        next_state = state;
        o_ctrl     = '0;
        o_ctrl.alu_op  = ALU_ADD;
        o_ctrl.imm_sel = IMM_I;
        case (state)
            S_IDLE: begin
                if (i_start) next_state = S_FETCH;
            end
            S_FETCH: begin
                next_state = S_DECODE;
            end
            S_DECODE: begin
                // PC + 4 into the PC, old PC kept for targets.
                o_ctrl.instr_we   = 1'b1;
                o_ctrl.old_pc_we  = 1'b1;
                o_ctrl.pc_we      = 1'b1;
                o_ctrl.alu_src_a  = 2'd0;
                o_ctrl.alu_src_b  = 2'd2;
                o_ctrl.result_src = 2'd2;
                case (i_dec.opcode)
                    OP_R:      next_state = S_EXEC_R;
                    OP_IMM:    next_state = S_EXEC_I;
                    OP_LOAD:   next_state = S_MEM_ADDR;
                    OP_STORE:  next_state = S_MEM_ADDR;
                    OP_BRANCH: next_state = S_BRANCH;
                    OP_JAL:    next_state = S_JAL;
                    OP_LUI:    next_state = S_LUI;
                    default:   next_state = S_HALT;
                endcase
            end
            S_EXEC_R: begin
                o_ctrl.alu_src_a = 2'd2;
                o_ctrl.alu_src_b = 2'd0;
                o_ctrl.alu_op    = r_alu_op;
                next_state       = S_ALU_WB;
            end
            S_EXEC_I: begin
                o_ctrl.alu_src_a = 2'd2;
                o_ctrl.alu_src_b = 2'd1;
                next_state       = S_ALU_WB;
            end
            S_MEM_ADDR: begin
                // Address goes straight to memory for loads.
                o_ctrl.alu_src_a  = 2'd2;
                o_ctrl.alu_src_b  = 2'd1;
                o_ctrl.imm_sel    = (i_dec.opcode == OP_STORE) ? IMM_S : IMM_I;
                o_ctrl.result_src = 2'd2;
                o_ctrl.addr_src   = 1'b1;
                next_state = (i_dec.opcode == OP_STORE) ? S_MEM_WRITE : S_MEM_READ;
            end
            S_MEM_READ: begin
                next_state = S_MEM_WB;
            end
            S_MEM_WB: begin
                o_ctrl.result_src = 2'd1;
                o_ctrl.reg_we     = 1'b1;
                next_state        = S_FETCH;
            end
            S_MEM_WRITE: begin
                o_ctrl.result_src = 2'd0;
                o_ctrl.addr_src   = 1'b1;
                o_ctrl.mem_we     = 1'b1;
                next_state        = S_FETCH;
            end
            S_BRANCH: begin
                o_ctrl.alu_src_a = 2'd2;
                o_ctrl.alu_src_b = 2'd0;
                o_ctrl.alu_op    = ALU_SUB;
                o_ctrl.imm_sel   = IMM_B;
                // BEQ on funct3 000, BNE on 001.
                o_ctrl.branch_take = i_dec.funct3[0] ? !i_dec.zero : i_dec.zero;
                next_state       = S_FETCH;
            end
            S_JAL: begin
                // Return address into ALU-out, target into PC.
                o_ctrl.alu_src_a   = 2'd1;
                o_ctrl.alu_src_b   = 2'd2;
                o_ctrl.imm_sel     = IMM_J;
                o_ctrl.branch_take = 1'b1;
                next_state         = S_ALU_WB;
            end
            S_LUI: begin
                o_ctrl.imm_sel    = IMM_U;
                o_ctrl.result_src = 2'd3;
                o_ctrl.reg_we     = 1'b1;
                next_state        = S_FETCH;
            end
            S_ALU_WB: begin
                o_ctrl.result_src = 2'd0;
                o_ctrl.reg_we     = 1'b1;
                next_state        = S_FETCH;
            end
            default: begin
                next_state = S_HALT;
            end
        endcase
    end

    assign o_halt = (state == S_HALT);
    assign o_busy = (state != S_IDLE) && (state != S_HALT);

endmodule

// ==== src/core_datapath.sv ====
/*
 * Multicycle datapath with its nonarchitectural registers, operand and result
 * muxes, PC logic, register file, ALU, immediate decoder and write-back trace.
 */

`timescale 1ns/1ps

module core_datapath
    import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  ctrl_t    i_ctrl,
    input  instr_t   i_instr,
    input  xlen_t    i_rdata,
    output decode_t  o_dec,
    output addr_t    o_mem_addr,
    output xlen_t    o_mem_wdata,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_rd,
    output xlen_t    o_wb_data
);

    instr_t instr_q, cur_instr;
    addr_t  pc_q, old_pc_q, target;
    xlen_t  a_q, b_q, alu_out_q, mdr_q;
    xlen_t  rdata1, rdata2, imm, src_a, src_b, alu_result, result;
    logic   zero;

    // Instruction is used straight from memory while it is being latched.
    assign cur_instr = i_ctrl.instr_we ? i_instr : instr_q;

    assign o_dec.opcode   = opcode_e'(cur_instr[6:0]);
    assign o_dec.funct3   = cur_instr[14:12];
    assign o_dec.funct7_5 = cur_instr[30];
    assign o_dec.zero     = zero;

    //--------------------------------------------------
    // Functional units.
    //--------------------------------------------------
    register_file u_regfile (
        .i_clk    ( i_clk             ),
        .i_rst_n  ( i_rst_n           ),
        .i_we     ( i_ctrl.reg_we     ),
        .i_rs1    ( cur_instr[19:15]  ),
        .i_rs2    ( cur_instr[24:20]  ),
        .i_rd     ( cur_instr[11:7]   ),
        .i_wdata  ( result            ),
        .o_rdata1 ( rdata1            ),
        .o_rdata2 ( rdata2            )
    );

    imm_extend u_imm (
        .i_sel   ( i_ctrl.imm_sel ),
        .i_instr ( cur_instr      ),
        .o_imm   ( imm            )
    );

    alu u_alu (
        .i_op     ( i_ctrl.alu_op ),
        .i_a      ( src_a         ),
        .i_b      ( src_b         ),
        .o_result ( alu_result    ),
        .o_zero   ( zero          )
    );

    //--------------------------------------------------
    // Muxes.
    //--------------------------------------------------
    always_comb begin
        case (i_ctrl.alu_src_a)
            2'd0:    src_a = pc_q;
            2'd1:    src_a = old_pc_q;
            default: src_a = a_q;
        endcase
        case (i_ctrl.alu_src_b)
            2'd0:    src_b = b_q;
            2'd1:    src_b = imm;
            default: src_b = 64'd4;
        endcase
        case (i_ctrl.result_src)
            2'd0:    result = alu_out_q;
            2'd1:    result = mdr_q;
            2'd2:    result = alu_result;
            default: result = imm;
        endcase
    end

    // Branch and jump target is added beside the ALU while it compares.
    assign target = old_pc_q + imm;

    assign o_mem_addr  = i_ctrl.addr_src ? result : pc_q;
    assign o_mem_wdata = b_q;

    //--------------------------------------------------
    // Registers.
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            instr_q  <= '0;
            pc_q     <= '0;
            old_pc_q <= '0;
        end else begin
            if (i_ctrl.instr_we)  instr_q  <= i_instr;
            if (i_ctrl.old_pc_we) old_pc_q <= pc_q;
            if (i_ctrl.branch_take) begin
                pc_q <= target;
            end else if (i_ctrl.pc_we) begin
                pc_q <= result;
            end
        end
    end

    // Payload registers load every cycle.
    always_ff @(posedge i_clk) begin
        a_q       <= rdata1;
        b_q       <= rdata2;
        alu_out_q <= alu_result;
        mdr_q     <= i_rdata;
    end

    // Write-back trace.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_ctrl.reg_we && (cur_instr[11:7] != '0);
        end
        o_wb_rd   <= cur_instr[11:7];
        o_wb_data <= result;
    end

endmodule

// ==== src/imm_extend.sv ====
/*
 * Immediate decoder for I, S, B, J and U formats, sign-extended to 64 bits.
 */

`timescale 1ns/1ps

module imm_extend
    import rv_pkg::*;
(
    input  imm_sel_e i_sel,
    input  instr_t   i_instr,
    output xlen_t    o_imm
);

    always_comb begin
        case (i_sel)
            IMM_I: o_imm = {{52{i_instr[31]}}, i_instr[31:20]};
            IMM_S: o_imm = {{52{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B: o_imm = {{52{i_instr[31]}}, i_instr[7], i_instr[30:25],
                            i_instr[11:8], 1'b0};
            IMM_J: o_imm = {{44{i_instr[31]}}, i_instr[19:12], i_instr[20],
                            i_instr[30:21], 1'b0};
            IMM_U: o_imm = {{32{i_instr[31]}}, i_instr[31:12], 12'b0};
            default: o_imm = '0;
        endcase
    end

endmodule

// ==== src/local_mem.sv ====
/*
 * Local instruction and data arrays, both read synchronously,
 * instruction array loaded through the program port.
 */

`timescale 1ns/1ps

module local_mem
    import rv_pkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
)
(
    input  logic   i_clk,
    input  logic   i_prog_we,
    input  addr_t  i_prog_addr,
    input  instr_t i_prog_data,
    input  addr_t  i_addr,
    input  logic   i_we,
    input  xlen_t  i_wdata,
    output instr_t o_instr,
    output xlen_t  o_rdata
);

    localparam int IW = $clog2(IMEM_WORDS);
    localparam int DW = $clog2(DMEM_WORDS);

    instr_t imem [IMEM_WORDS];
    xlen_t  dmem [DMEM_WORDS];

    logic [IW-1:0] i_idx, p_idx;
    logic [DW-1:0] d_idx;

    // Word index above the byte offset.
    assign i_idx = i_addr[IW+1:2];
    assign p_idx = i_prog_addr[IW+1:2];
    assign d_idx = i_addr[DW+2:3];

    always_ff @(posedge i_clk) begin
        if (i_prog_we) begin
            imem[p_idx] <= i_prog_data;
        end
        o_instr <= imem[i_idx];
    end

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            dmem[d_idx] <= i_wdata;
        end
        o_rdata <= dmem[d_idx];
    end

endmodule

// ==== src/register_file.sv ====
/*
 * 32 x 64 register file with two async reads, one sync write and x0 fixed at zero.
 */

`timescale 1ns/1ps

module register_file
    import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_we,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_rd,
    input  xlen_t    i_wdata,
    output xlen_t    o_rdata1,
    output xlen_t    o_rdata2
);

    xlen_t regs [32];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_rs1];
    assign o_rdata2 = regs[i_rs2];

endmodule

// ==== src/rv_core_top.sv ====
/*
 * Top of the multicycle RV64I core with control FSM, datapath and local memory.
 */

`timescale 1ns/1ps

module rv_core_top
    import rv_pkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
)
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_prog_we,
    input  addr_t    i_prog_addr,
    input  instr_t   i_prog_data,
    input  logic     i_start,
    output logic     o_busy,
    output logic     o_halt,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_rd,
    output xlen_t    o_wb_data
);

    ctrl_t   ctrl;
    decode_t dec;
    addr_t   mem_addr;
    xlen_t   mem_wdata, rdata;
    instr_t  instr;
    logic    prog_we;

    // Program writes only while the core is not running.
    assign prog_we = i_prog_we && !o_busy;

    control_fsm u_ctrl (
        .i_clk   ( i_clk   ),
        .i_rst_n ( i_rst_n ),
        .i_start ( i_start ),
        .i_dec   ( dec     ),
        .o_ctrl  ( ctrl    ),
        .o_busy  ( o_busy  ),
        .o_halt  ( o_halt  )
    );

    core_datapath u_dp (
        .i_clk       ( i_clk      ),
        .i_rst_n     ( i_rst_n    ),
        .i_ctrl      ( ctrl       ),
        .i_instr     ( instr      ),
        .i_rdata     ( rdata      ),
        .o_dec       ( dec        ),
        .o_mem_addr  ( mem_addr   ),
        .o_mem_wdata ( mem_wdata  ),
        .o_wb_valid  ( o_wb_valid ),
        .o_wb_rd     ( o_wb_rd    ),
        .o_wb_data   ( o_wb_data  )
    );

    local_mem #(
        .IMEM_WORDS ( IMEM_WORDS ),
        .DMEM_WORDS ( DMEM_WORDS )
    ) u_mem (
        .i_clk       ( i_clk       ),
        .i_prog_we   ( prog_we     ),
        .i_prog_addr ( i_prog_addr ),
        .i_prog_data ( i_prog_data ),
        .i_addr      ( mem_addr    ),
        .i_we        ( ctrl.mem_we ),
        .i_wdata     ( mem_wdata   ),
        .o_instr     ( instr       ),
        .o_rdata     ( rdata       )
    );

endmodule

// ==== src/rv_pkg.sv ====
/*
 * Shared types of the multicycle RV64I core with width typedefs,
 * opcode, ALU, immediate and FSM state enums, and the control and decode structs.
 */

package rv_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_J, IMM_U
    } imm_sel_e;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LUI    = 7'b0110111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        S_IDLE, S_FETCH, S_DECODE, S_EXEC_R, S_EXEC_I, S_MEM_ADDR, S_MEM_READ,
        S_MEM_WB, S_MEM_WRITE, S_BRANCH, S_JAL, S_LUI, S_ALU_WB, S_HALT
    } fsm_state_e;

    // Operand A selects 0 PC, 1 old PC, 2 register A.
    // Operand B selects 0 register B, 1 immediate, 2 four.
    // Result selects 0 ALU-out reg, 1 memory-data reg, 2 ALU, 3 immediate.
    typedef struct packed {
        logic      instr_we;
        logic      pc_we;
        logic      old_pc_we;
        logic [1:0] alu_src_a;
        logic [1:0] alu_src_b;
        alu_op_e   alu_op;
        imm_sel_e  imm_sel;
        logic [1:0] result_src;
        logic      addr_src;
        logic      reg_we;
        logic      mem_we;
        logic      branch_take;
    } ctrl_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        logic       funct7_5;
        logic       zero;
    } decode_t;

endpackage

// ==== verif/tb_rv_core.sv ====
/*
 * Directed testbench for the multicycle RV64I core with instruction encoders,
 * program loader, reference model, run task and write-back checks.
 */

`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam int IMEM_WORDS  = 256;
    localparam int DMEM_WORDS  = 256;
    localparam int RUN_TIMEOUT = 4000;
    localparam instr_t ECALL_WORD = 32'h0000_0073;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

    logic     clk;
    logic     rst_n;
    logic     prog_we;
    addr_t    prog_addr;
    instr_t   prog_data;
    logic     start;
    logic     busy;
    logic     halt;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;

    instr_t      prog [$];
    wb_t         exp_q [$];
    wb_t         got_q [$];
    logic [15:0] lfsr_state = 16'd59647;
    int          errors = 0;
    int          checks = 0;

    rv_core_top #(
        .IMEM_WORDS ( IMEM_WORDS ),
        .DMEM_WORDS ( DMEM_WORDS )
    ) i_dut (
        .i_clk       ( clk       ),
        .i_rst_n     ( rst_n     ),
        .i_prog_we   ( prog_we   ),
        .i_prog_addr ( prog_addr ),
        .i_prog_data ( prog_data ),
        .i_start     ( start     ),
        .o_busy      ( busy      ),
        .o_halt      ( halt      ),
        .o_wb_valid  ( wb_valid  ),
        .o_wb_rd     ( wb_rd     ),
        .o_wb_data   ( wb_data   )
    );

    always #5 clk = ~clk;

    //--------------------------------------------------
    // Random bits and instruction encoders.
    //--------------------------------------------------
    // Galois LFSR with taps 16, 14, 13 and 11.
    function automatic logic next_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]};
        if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], next_bit()};
        end
        return v;
    endfunction

    function automatic instr_t r_type(logic [6:0] f7, logic [2:0] f3,
                                      reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic instr_t load_d(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic instr_t store_d(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    // BEQ is funct3 000, BNE is 001.
    function automatic instr_t branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                      logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic instr_t jal(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic instr_t lui(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    //--------------------------------------------------
    // Reset, program load and reference model.
    //--------------------------------------------------
    task automatic reset_dut();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic load_program();
        if (prog.size() > IMEM_WORDS) begin
            $display("ERROR: program of %0d words does not fit the instruction array",
                     prog.size());
            errors++;
        end
        for (int i = 0; i < prog.size() && i < IMEM_WORDS; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_t'(i) << 2;
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // Executes the program word by word and lists the expected writes.
    task automatic predict_writes();
        xlen_t  regs [32];
        xlen_t  dmem [addr_t];
        addr_t  pc;
        addr_t  pc_next;
        addr_t  dw_addr;
        instr_t ins;
        xlen_t  a;
        xlen_t  b;
        xlen_t  res;
        xlen_t  imm_i, imm_s, imm_b, imm_j, imm_u;
        logic   wr;
        logic   done;
        int     idx;
        int     steps;
        wb_t    ev;

        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            idx = int'(pc >> 2);
            if (idx >= prog.size() || steps >= 1000) begin
                $display("ERROR: reference model left the program at pc %h", pc);
                errors++;
                done = 1'b1;
            end else begin
                steps++;
                ins     = prog[idx];
                a       = regs[ins[19:15]];
                b       = regs[ins[24:20]];
                imm_i   = {{52{ins[31]}}, ins[31:20]};
                imm_s   = {{52{ins[31]}}, ins[31:25], ins[11:7]};
                imm_b   = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                imm_j   = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                imm_u   = {{32{ins[31]}}, ins[31:12], 12'h000};
                wr      = 1'b0;
                res     = '0;
                pc_next = pc + 64'd4;
                case (ins[6:0])
                    OP_R: begin
                        wr = 1'b1;
                        case (ins[14:12])
                            3'b000:  res = ins[30] ? a - b : a + b;
                            3'b010:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                            3'b011:  res = (a < b) ? 64'd1 : 64'd0;
                            3'b100:  res = a ^ b;
                            3'b110:  res = a | b;
                            default: res = a & b;
                        endcase
                    end
                    OP_IMM: begin
                        wr  = 1'b1;
                        res = a + imm_i;
                    end
                    OP_LUI: begin
                        wr  = 1'b1;
                        res = imm_u;
                    end
                    OP_LOAD: begin
                        dw_addr      = a + imm_i;
                        dw_addr[2:0] = 3'b000;
                        wr           = 1'b1;
                        res          = dmem.exists(dw_addr) ? dmem[dw_addr] : '0;
                    end
                    OP_STORE: begin
                        dw_addr       = a + imm_s;
                        dw_addr[2:0]  = 3'b000;
                        dmem[dw_addr] = b;
                    end
                    OP_BRANCH: begin
                        if ((a == b) != ins[12]) begin
                            pc_next = pc + imm_b;
                        end
                    end
                    OP_JAL: begin
                        wr      = 1'b1;
                        res     = pc + 64'd4;
                        pc_next = pc + imm_j;
                    end
                    // ECALL and anything unknown stop the core.
                    default: done = 1'b1;
                endcase
                if (wr && ins[11:7] != 5'd0) begin
                    regs[ins[11:7]] = res;
                    ev.rd   = ins[11:7];
                    ev.data = res;
                    exp_q.push_back(ev);
                end
                pc = pc_next;
            end
        end
    endtask

    //--------------------------------------------------
    // Run and compare.
    //--------------------------------------------------
    task automatic run_to_halt(string name);
        int  cycles;
        wb_t ev;

        got_q.delete();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (!halt && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (wb_valid) begin
                ev.rd   = wb_rd;
                ev.data = wb_data;
                got_q.push_back(ev);
            end
            if (!halt && !busy) begin
                $display("ERROR: %s core not busy while running", name);
                errors++;
            end
        end
        if (!halt) begin
            $display("ERROR: %s timed out after %0d cycles waiting for halt", name, cycles);
            errors++;
        end
    endtask

    task automatic compare_writes(string name);
        checks++;
        if (got_q.size() != exp_q.size()) begin
            $display("CHECK FAILED %s write count: expected %0d, actual %0d",
                     name, exp_q.size(), got_q.size());
            errors++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            checks++;
            if (got_q[i] !== exp_q[i]) begin
                $display("CHECK FAILED %s write %0d: expected x%0d = %h, actual x%0d = %h",
                         name, i, exp_q[i].rd, exp_q[i].data, got_q[i].rd, got_q[i].data);
                errors++;
            end
        end
        for (int i = 0; i < got_q.size(); i++) begin
            if (got_q[i].rd == 5'd0) begin
                $display("ERROR: %s trace shows a write to x0", name);
                errors++;
            end
        end
    endtask

    task automatic run_program(string name);
        reset_dut();
        load_program();
        predict_writes();
        run_to_halt(name);
        compare_writes(name);
    endtask

    //--------------------------------------------------
    // Directed tests.
    //--------------------------------------------------
    task automatic addi_lui_seq();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'(rand_bits(12))));
        prog.push_back(addi(5'd2, 5'd1, 12'(rand_bits(12))));
        prog.push_back(addi(5'd0, 5'd1, 12'(rand_bits(12))));
        prog.push_back(addi(5'd5, 5'd0, 12'hfff));
        prog.push_back(lui(5'd3, 20'(rand_bits(20))));
        prog.push_back(lui(5'd0, 20'(rand_bits(20))));
        prog.push_back(lui(5'd6, 20'h80000));
        prog.push_back(addi(5'd4, 5'd3, 12'(rand_bits(12))));
        prog.push_back(ECALL_WORD);
        run_program("addi_lui");
    endtask

    task automatic alu_ops();
        prog.delete();
        prog.push_back(lui(5'd1, 20'(rand_bits(20))));
        prog.push_back(addi(5'd1, 5'd1, 12'(rand_bits(12))));
        prog.push_back(lui(5'd2, 20'(rand_bits(20))));
        prog.push_back(addi(5'd2, 5'd2, 12'(rand_bits(12))));
        prog.push_back(addi(5'd3, 5'd0, 12'hfff));
        prog.push_back(addi(5'd4, 5'd0, 12'd1));
        prog.push_back(r_type(7'b0000000, 3'b000, 5'd5, 5'd1, 5'd2));
        prog.push_back(r_type(7'b0100000, 3'b000, 5'd6, 5'd1, 5'd2));
        prog.push_back(r_type(7'b0000000, 3'b111, 5'd7, 5'd1, 5'd2));
        prog.push_back(r_type(7'b0000000, 3'b110, 5'd8, 5'd1, 5'd2));
        prog.push_back(r_type(7'b0000000, 3'b100, 5'd9, 5'd1, 5'd2));
        prog.push_back(r_type(7'b0000000, 3'b010, 5'd10, 5'd1, 5'd2));
        prog.push_back(r_type(7'b0000000, 3'b011, 5'd11, 5'd1, 5'd2));
        // Minus one compared with one in both orders and both signednesses.
        prog.push_back(r_type(7'b0000000, 3'b010, 5'd12, 5'd3, 5'd4));
        prog.push_back(r_type(7'b0000000, 3'b011, 5'd13, 5'd3, 5'd4));
        prog.push_back(r_type(7'b0000000, 3'b010, 5'd14, 5'd4, 5'd3));
        prog.push_back(r_type(7'b0000000, 3'b011, 5'd15, 5'd4, 5'd3));
        prog.push_back(ECALL_WORD);
        run_program("alu_ops");
    endtask

    task automatic load_store();
        prog.delete();
        prog.push_back(lui(5'd1, 20'(rand_bits(20))));
        prog.push_back(addi(5'd1, 5'd1, 12'(rand_bits(12))));
        prog.push_back(addi(5'd2, 5'd0, 12'd64));
        prog.push_back(store_d(5'd1, 5'd2, 12'd8));
        prog.push_back(load_d(5'd3, 5'd2, 12'd8));
        prog.push_back(load_d(5'd4, 5'd2, 12'd24));
        // Same doubleword through another base and a negative offset.
        prog.push_back(addi(5'd5, 5'd2, 12'hff8));
        prog.push_back(load_d(5'd6, 5'd5, 12'd16));
        prog.push_back(ECALL_WORD);
        run_program("load_store");
    endtask

    task automatic branch_jal();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd2, 5'd0, 12'd5));
        prog.push_back(branch(3'b000, 5'd1, 5'd2, 13'd8));
        prog.push_back(addi(5'd10, 5'd0, 12'd1));
        prog.push_back(branch(3'b001, 5'd1, 5'd2, 13'd8));
        prog.push_back(addi(5'd11, 5'd0, 12'd2));
        prog.push_back(addi(5'd2, 5'd0, 12'd7));
        prog.push_back(branch(3'b001, 5'd1, 5'd2, 13'd8));
        prog.push_back(addi(5'd12, 5'd0, 12'd3));
        prog.push_back(branch(3'b000, 5'd1, 5'd2, 13'd8));
        prog.push_back(addi(5'd13, 5'd0, 12'd4));
        prog.push_back(jal(5'd5, 21'd8));
        prog.push_back(addi(5'd14, 5'd0, 12'd5));
        prog.push_back(branch(3'b000, 5'd0, 5'd0, 13'd8));
        prog.push_back(addi(5'd15, 5'd0, 12'd6));
        prog.push_back(ECALL_WORD);
        run_program("branch_jal");
    endtask

    task automatic ecall_halt();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'(rand_bits(12))));
        prog.push_back(ECALL_WORD);
        prog.push_back(addi(5'd2, 5'd0, 12'd1));
        prog.push_back(addi(5'd3, 5'd0, 12'd2));
        run_program("ecall_halt");
        checks++;
        if (!halt || busy) begin
            $display("CHECK FAILED %s status: expected halt=1 busy=0, actual halt=%b busy=%b",
                     "ecall_halt", halt, busy);
            errors++;
        end
        // Quiet window after the halt.
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (wb_valid || !halt) begin
                $display("ERROR: ecall_halt activity after halt, wb_valid=%b halt=%b",
                         wb_valid, halt);
                errors++;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        start     <= 1'b0;
        addi_lui_seq();
        alu_ops();
        load_store();
        branch_jal();
        ecall_halt();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
